//--- csr_settings.svh
// CSR unit build constants
`ifndef CSR_SETTINGS_SVH
`define CSR_SETTINGS_SVH

////////////////////////////////////////
// Datapath widths

`define CSR_XLEN 32
`define CSR_COUNTER_W 64

// Cycle and instret
`define CSR_NUM_COUNTERS 2

////////////////////////////////////////
// Reset and identification values

// Trap vector out of reset
`define CSR_RESET_VEC 32'h0000_0100

// RV32 with I and U
`define CSR_MISA 32'h4010_0100

`define CSR_IMPL_ID 32'h0000_0001
`define CSR_HART_ID 32'h0000_0000

`endif

//--- csr_pkg.sv
// CSR unit shared types
`include "csr_settings.svh"

package csr_pkg;

    ////////////////////////////////////////
    // Privilege and operation encodings

    typedef enum logic [1:0] {
        USER_PRIV    = 2'b00,
        MACHINE_PRIV = 2'b11
    } privilege_t;

    // Matches funct3[1:0] of the CSR instructions
    typedef enum logic [1:0] {
        CSR_RW = 2'b01,
        CSR_RS = 2'b10,
        CSR_RC = 2'b11
    } csr_op_t;

    ////////////////////////////////////////
    // Address views

    typedef struct packed {
        logic [1:0] rw_bits;
        logic [1:0] privilege;
        logic [7:0] sub_addr;
    } csr_addr_fields_t;

    typedef union packed {
        logic [11:0]      raw;
        csr_addr_fields_t fields;
    } csr_addr_u;

    // Address map
    localparam logic [11:0] ADDR_MSTATUS   = 12'h300;
    localparam logic [11:0] ADDR_MISA      = 12'h301;
    localparam logic [11:0] ADDR_MTVEC     = 12'h305;
    localparam logic [11:0] ADDR_MSCRATCH  = 12'h340;
    localparam logic [11:0] ADDR_MEPC      = 12'h341;
    localparam logic [11:0] ADDR_MCAUSE    = 12'h342;
    localparam logic [11:0] ADDR_MTVAL     = 12'h343;
    localparam logic [11:0] ADDR_MVENDORID = 12'hF11;
    localparam logic [11:0] ADDR_MARCHID   = 12'hF12;
    localparam logic [11:0] ADDR_MIMPID    = 12'hF13;
    localparam logic [11:0] ADDR_MHARTID   = 12'hF14;

    // Counter half bases, machine and user alias
    localparam logic [11:0] ADDR_MCOUNTER_LO = 12'hB00;
    localparam logic [11:0] ADDR_MCOUNTER_HI = 12'hB80;
    localparam logic [11:0] ADDR_UCOUNTER_LO = 12'hC00;
    localparam logic [11:0] ADDR_UCOUNTER_HI = 12'hC80;

    // Slot 1 is time, which this unit lacks, so counters sit two apart
    function automatic logic [11:0] counter_addr(logic [11:0] base, int idx);
        return base + 12'(2 * idx);
    endfunction

    ////////////////////////////////////////
    // Request and response

    typedef struct packed {
        csr_addr_u            addr;
        csr_op_t              op;
        logic [`CSR_XLEN-1:0] wdata;
    } csr_req_t;

    typedef struct packed {
        logic [`CSR_XLEN-1:0] rdata;
        logic                 illegal;
    } csr_rsp_t;

    typedef struct packed {
        logic [`CSR_XLEN-1:0] pc;
        logic [3:0]           code;
        logic [`CSR_XLEN-1:0] tval;
    } trap_req_t;

    ////////////////////////////////////////
    // Trap register state

    typedef struct packed {
        logic [18:0] zero_31_13;
        logic [1:0]  mpp;
        logic [2:0]  zero_10_8;
        logic        mpie;
        logic [2:0]  zero_6_4;
        logic        mie;
        logic [2:0]  zero_2_0;
    } mstatus_t;

    typedef struct packed {
        mstatus_t             mstatus;
        logic [`CSR_XLEN-1:0] mtvec;
        logic [`CSR_XLEN-1:0] mepc;
        logic [`CSR_XLEN-1:0] mcause;
        logic [`CSR_XLEN-1:0] mtval;
        logic [`CSR_XLEN-1:0] mscratch;
        privilege_t           priv;
    } trap_state_t;

    ////////////////////////////////////////
    // Write strobes

    typedef enum logic [3:0] {
        SEL_NONE,
        SEL_MSTATUS,
        SEL_MTVEC,
        SEL_MEPC,
        SEL_MCAUSE,
        SEL_MTVAL,
        SEL_MSCRATCH
    } csr_sel_t;

    typedef struct packed {
        csr_sel_t             sel;
        logic [`CSR_XLEN-1:0] value;
    } csr_wr_t;

    typedef struct packed {
        logic                 inc;
        logic                 wr_lo;
        logic                 wr_hi;
        logic [`CSR_XLEN-1:0] value;
    } counter_ctl_t;

endpackage

//--- csr_access.sv
// CSR access decoder
`timescale 1ns/100ps
`include "csr_settings.svh"

module csr_access (
    input  logic                                          req_valid,
    input  csr_pkg::csr_req_t                             req,
    input  csr_pkg::privilege_t                           priv,
    input  logic [`CSR_XLEN-1:0]                          old_value,
    input  logic                                          addr_known,
    input  logic                                          inst_retired,
    output csr_pkg::csr_wr_t                              wr,
    output csr_pkg::counter_ctl_t [`CSR_NUM_COUNTERS-1:0] counter_ctl,
    output logic                                          illegal
);

    logic                 priv_fail;
    logic                 read_only;
    logic                 do_write;
    logic [`CSR_XLEN-1:0] new_value;

    ////////////////////////////////////////
    // Access checks

    // Address privilege above current mode
    assign priv_fail = req.addr.fields.privilege > priv;
    assign read_only = req.addr.fields.rw_bits == 2'b11;

    assign illegal  = req_valid && (!addr_known || priv_fail);
    // Read-only targets stay legal, the write is just dropped
    assign do_write = req_valid && !illegal && !read_only;

    ////////////////////////////////////////
    // New value

    always_comb begin
        case (req.op)
            csr_pkg::CSR_RS: new_value = old_value | req.wdata;
            csr_pkg::CSR_RC: new_value = old_value & ~req.wdata;
            default:         new_value = req.wdata;
        endcase
    end

    ////////////////////////////////////////
    // Trap register strobes

    always_comb begin
        wr.value = new_value;
        wr.sel   = csr_pkg::SEL_NONE;
        if (do_write) begin
            case (req.addr.raw)
                csr_pkg::ADDR_MSTATUS:  wr.sel = csr_pkg::SEL_MSTATUS;
                csr_pkg::ADDR_MTVEC:    wr.sel = csr_pkg::SEL_MTVEC;
                csr_pkg::ADDR_MEPC:     wr.sel = csr_pkg::SEL_MEPC;
                csr_pkg::ADDR_MCAUSE:   wr.sel = csr_pkg::SEL_MCAUSE;
                csr_pkg::ADDR_MTVAL:    wr.sel = csr_pkg::SEL_MTVAL;
                csr_pkg::ADDR_MSCRATCH: wr.sel = csr_pkg::SEL_MSCRATCH;
                // misa is mapped but fixed
                default:                wr.sel = csr_pkg::SEL_NONE;
            endcase
        end
    end

    ////////////////////////////////////////
    // Counter strobes

    always_comb begin
        for (int i = 0; i < `CSR_NUM_COUNTERS; i++) begin
            // Counter 0 counts cycles, the rest count retired instructions
            counter_ctl[i].inc   = (i == 0) ? 1'b1 : inst_retired;
            counter_ctl[i].wr_lo = do_write &&
                req.addr.raw == csr_pkg::counter_addr(csr_pkg::ADDR_MCOUNTER_LO, i);
            counter_ctl[i].wr_hi = do_write &&
                req.addr.raw == csr_pkg::counter_addr(csr_pkg::ADDR_MCOUNTER_HI, i);
            counter_ctl[i].value = new_value;
        end
    end

endmodule

//--- csr_trap.sv
// Machine trap registers
`timescale 1ns/100ps
`include "csr_settings.svh"

module csr_trap (
    input  logic                   clk,
    input  logic                   rst,
    input  csr_pkg::csr_wr_t       wr,
    input  logic                   trap_valid,
    input  csr_pkg::trap_req_t     trap,
    input  logic                   mret,
    output csr_pkg::trap_state_t   state
);

    localparam csr_pkg::trap_state_t RESET_STATE = '{
        mstatus: '{mpp: 2'b11, default: '0},
        mtvec:   `CSR_RESET_VEC,
        priv:    csr_pkg::MACHINE_PRIV,
        default: '0
    };

    csr_pkg::trap_state_t state_q;
    csr_pkg::trap_state_t state_d;
    csr_pkg::mstatus_t    wr_status;

    // Software view of the written word
    assign wr_status = csr_pkg::mstatus_t'(wr.value);

    ////////////////////////////////////////
    // Next state

    always_comb begin
        state_d = state_q;
        if (trap_valid) begin
            state_d.priv         = csr_pkg::MACHINE_PRIV;
            state_d.mstatus.mpp  = state_q.priv;
            state_d.mstatus.mpie = state_q.mstatus.mie;
            state_d.mstatus.mie  = 1'b0;
            state_d.mepc         = {trap.pc[`CSR_XLEN-1:2], 2'b00};
            state_d.mcause       = {{(`CSR_XLEN-4){1'b0}}, trap.code};
            state_d.mtval        = trap.tval;
        end else if (mret) begin
            // mpp only ever holds 00 or 11
            state_d.priv         = csr_pkg::privilege_t'(state_q.mstatus.mpp);
            state_d.mstatus.mie  = state_q.mstatus.mpie;
            state_d.mstatus.mpie = 1'b1;
            state_d.mstatus.mpp  = csr_pkg::USER_PRIV;
        end else begin
            case (wr.sel)
                csr_pkg::SEL_MSTATUS: begin
                    state_d.mstatus.mie  = wr_status.mie;
                    state_d.mstatus.mpie = wr_status.mpie;
                    // No supervisor, so the upper bit picks user or machine
                    state_d.mstatus.mpp  = {2{wr_status.mpp[1]}};
                end
                csr_pkg::SEL_MTVEC: begin
                    state_d.mtvec = {wr.value[`CSR_XLEN-1:2], 2'b00};
                end
                csr_pkg::SEL_MEPC: begin
                    state_d.mepc = {wr.value[`CSR_XLEN-1:2], 2'b00};
                end
                csr_pkg::SEL_MCAUSE: begin
                    // Interrupt flag and exception code only
                    state_d.mcause = wr.value & 32'h8000_000F;
                end
                csr_pkg::SEL_MTVAL: begin
                    state_d.mtval = wr.value;
                end
                csr_pkg::SEL_MSCRATCH: begin
                    state_d.mscratch = wr.value;
                end
                default: begin
                    state_d = state_q;
                end
            endcase
        end
    end

    ////////////////////////////////////////
    // State register

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= RESET_STATE;
        end else begin
            state_q <= state_d;
        end
    end

    assign state = state_q;

endmodule

//--- csr_counter.sv
// 64-bit event counter
`timescale 1ns/100ps
`include "csr_settings.svh"

module csr_counter (
    input  logic                       clk,
    input  logic                       rst,
    input  csr_pkg::counter_ctl_t      ctl,
    output logic [`CSR_COUNTER_W-1:0]  count
);

    logic [`CSR_COUNTER_W-1:0] count_q;

    ////////////////////////////////////////
    // Count and half-word writes

    // A software write wins over the increment for that cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            count_q <= '0;
        end else if (ctl.wr_lo) begin
            count_q[`CSR_XLEN-1:0] <= ctl.value;
        end else if (ctl.wr_hi) begin
            count_q[`CSR_COUNTER_W-1:`CSR_XLEN] <= ctl.value;
        end else if (ctl.inc) begin
            count_q <= count_q + `CSR_COUNTER_W'(1);
        end
    end

    assign count = count_q;

endmodule

//--- csr_read_select.sv
// CSR read mux and response register
`timescale 1ns/100ps
`include "csr_settings.svh"

module csr_read_select (
    input  logic                                              clk,
    input  logic                                              rst,
    input  logic                                              req_valid,
    input  csr_pkg::csr_req_t                                 req,
    input  csr_pkg::trap_state_t                              state,
    input  logic [`CSR_NUM_COUNTERS-1:0][`CSR_COUNTER_W-1:0]  counts,
    input  logic                                              illegal,
    output logic [`CSR_XLEN-1:0]                              old_value,
    output logic                                              addr_known,
    output logic                                              rsp_valid,
    output csr_pkg::csr_rsp_t                                 rsp
);

    ////////////////////////////////////////
    // Address map

    always_comb begin
        old_value  = '0;
        addr_known = 1'b1;
        case (req.addr.raw)
            // Identification
            csr_pkg::ADDR_MISA:      old_value = `CSR_MISA;
            csr_pkg::ADDR_MVENDORID: old_value = '0;
            csr_pkg::ADDR_MARCHID:   old_value = '0;
            csr_pkg::ADDR_MIMPID:    old_value = `CSR_IMPL_ID;
            csr_pkg::ADDR_MHARTID:   old_value = `CSR_HART_ID;
            // Trap setup and handling
            csr_pkg::ADDR_MSTATUS:   old_value = state.mstatus;
            csr_pkg::ADDR_MTVEC:     old_value = state.mtvec;
            csr_pkg::ADDR_MSCRATCH:  old_value = state.mscratch;
            csr_pkg::ADDR_MEPC:      old_value = state.mepc;
            csr_pkg::ADDR_MCAUSE:    old_value = state.mcause;
            csr_pkg::ADDR_MTVAL:     old_value = state.mtval;
            default: begin
                addr_known = 1'b0;
                // Counter halves and their user aliases
                for (int i = 0; i < `CSR_NUM_COUNTERS; i++) begin
                    if (req.addr.raw == csr_pkg::counter_addr(csr_pkg::ADDR_MCOUNTER_LO, i) ||
                        req.addr.raw == csr_pkg::counter_addr(csr_pkg::ADDR_UCOUNTER_LO, i)) begin
                        old_value  = counts[i][`CSR_XLEN-1:0];
                        addr_known = 1'b1;
                    end
                    if (req.addr.raw == csr_pkg::counter_addr(csr_pkg::ADDR_MCOUNTER_HI, i) ||
                        req.addr.raw == csr_pkg::counter_addr(csr_pkg::ADDR_UCOUNTER_HI, i)) begin
                        old_value  = counts[i][`CSR_COUNTER_W-1:`CSR_XLEN];
                        addr_known = 1'b1;
                    end
                end
            end
        endcase
    end

    ////////////////////////////////////////
    // Registered response

    always_ff @(posedge clk) begin
        if (rst) begin
            rsp_valid <= 1'b0;
            rsp       <= '0;
        end else begin
            rsp_valid   <= req_valid;
            // Rejected accesses return zero
            rsp.rdata   <= illegal ? '0 : old_value;
            rsp.illegal <= illegal;
        end
    end

endmodule

//--- csr_unit.sv
// Machine-mode CSR unit
`timescale 1ns/100ps
`include "csr_settings.svh"

module csr_unit (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   req_valid,
    input  csr_pkg::csr_req_t      req,
    output logic                   rsp_valid,
    output csr_pkg::csr_rsp_t      rsp,
    input  logic                   trap_valid,
    input  csr_pkg::trap_req_t     trap,
    input  logic                   mret,
    input  logic                   inst_retired,
    output csr_pkg::privilege_t    priv,
    output logic [`CSR_XLEN-1:0]   trap_vector,
    output logic [`CSR_XLEN-1:0]   epc
);

    csr_pkg::trap_state_t                              state;
    csr_pkg::csr_wr_t                                  wr;
    csr_pkg::counter_ctl_t [`CSR_NUM_COUNTERS-1:0]     counter_ctl;
    logic [`CSR_NUM_COUNTERS-1:0][`CSR_COUNTER_W-1:0]  counts;
    logic [`CSR_XLEN-1:0]                              old_value;
    logic                                              addr_known;
    logic                                              illegal;

    csr_access csr_access_i (
        .req_valid    (req_valid),
        .req          (req),
        .priv         (state.priv),
        .old_value    (old_value),
        .addr_known   (addr_known),
        .inst_retired (inst_retired),
        .wr           (wr),
        .counter_ctl  (counter_ctl),
        .illegal      (illegal)
    );

    csr_trap csr_trap_i (
        .clk        (clk),
        .rst        (rst),
        .wr         (wr),
        .trap_valid (trap_valid),
        .trap       (trap),
        .mret       (mret),
        .state      (state)
    );

    ////////////////////////////////////////
    // Cycle and instret counters

    for (genvar i = 0; i < `CSR_NUM_COUNTERS; i++) begin : gen_counter
        csr_counter csr_counter_i (
            .clk   (clk),
            .rst   (rst),
            .ctl   (counter_ctl[i]),
            .count (counts[i])
        );
    end

    csr_read_select csr_read_select_i (
        .clk        (clk),
        .rst        (rst),
        .req_valid  (req_valid),
        .req        (req),
        .state      (state),
        .counts     (counts),
        .illegal    (illegal),
        .old_value  (old_value),
        .addr_known (addr_known),
        .rsp_valid  (rsp_valid),
        .rsp        (rsp)
    );

    assign priv        = state.priv;
    assign trap_vector = state.mtvec;
    assign epc         = state.mepc;

endmodule

//--- csr_unit_properties.sv
// CSR unit response and trap checks
`timescale 1ns/100ps
`include "csr_settings.svh"

module csr_unit_properties (
    input logic                clk,
    input logic                rst,
    input logic                req_valid,
    input logic                rsp_valid,
    input csr_pkg::csr_rsp_t   rsp,
    input logic                trap_valid,
    input csr_pkg::privilege_t priv
);

    ////////////////////////////////////////
    // Response timing

    rsp_idle_after_reset: assert property (
        @(posedge clk) rst |=> !rsp_valid
    ) else $error("rsp_valid high right after a reset cycle");

    // One response per request, one cycle later
    rsp_follows_req: assert property (
        @(posedge clk) disable iff (rst) req_valid |=> rsp_valid
    ) else $error("request got no response in the next cycle");

    rsp_only_for_req: assert property (
        @(posedge clk) disable iff (rst) !req_valid |=> !rsp_valid
    ) else $error("response without a request in the previous cycle");

    illegal_zero_data: assert property (
        @(posedge clk) disable iff (rst) rsp_valid && rsp.illegal |-> rsp.rdata == '0
    ) else $error("illegal response carries nonzero data");

    ////////////////////////////////////////
    // Trap entry

    trap_enters_machine: assert property (
        @(posedge clk) disable iff (rst) trap_valid |=> priv == csr_pkg::MACHINE_PRIV
    ) else $error("priv not machine one cycle after trap entry");

endmodule

bind csr_unit csr_unit_properties csr_unit_properties_i (
    .clk        (clk),
    .rst        (rst),
    .req_valid  (req_valid),
    .rsp_valid  (rsp_valid),
    .rsp        (rsp),
    .trap_valid (trap_valid),
    .priv       (priv)
);

//--- csr_unit_tb.sv
// CSR unit testbench
`timescale 1ns/100ps
`include "csr_settings.svh"

module csr_unit_tb;

    // About twice the summed length of the tests
    localparam int unsigned TIMEOUT_CYCLES = 400;

    logic                 clk;
    logic                 rst;
    logic                 req_valid;
    csr_pkg::csr_req_t    req;
    logic                 rsp_valid;
    csr_pkg::csr_rsp_t    rsp;
    logic                 trap_valid;
    csr_pkg::trap_req_t   trap;
    logic                 mret;
    logic                 inst_retired;
    csr_pkg::privilege_t  priv;
    logic [`CSR_XLEN-1:0] trap_vector;
    logic [`CSR_XLEN-1:0] epc;

    int unsigned          cycles = 0;
    // mscratch as the read-modify-write test leaves it
    logic [`CSR_XLEN-1:0] scratch_model;

    csr_unit csr_unit_i (
        .clk          (clk),
        .rst          (rst),
        .req_valid    (req_valid),
        .req          (req),
        .rsp_valid    (rsp_valid),
        .rsp          (rsp),
        .trap_valid   (trap_valid),
        .trap         (trap),
        .mret         (mret),
        .inst_retired (inst_retired),
        .priv         (priv),
        .trap_vector  (trap_vector),
        .epc          (epc)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            abort_run($sformatf("Timeout, tests still running after %0d cycles", cycles));
        end
    end

    ////////////////////////////////////////
    // Error reporting and compares

    task automatic abort_run(input string line);
        $display("%s", line);
        $display("Some tests failed");
        $fatal(1, "Stopped at the first error");
    endtask

    task automatic check_rsp(input string name, input csr_pkg::csr_rsp_t expected);
        if (!rsp_valid) begin
            abort_run($sformatf("No response for %s one cycle after its request", name));
        end
        if (rsp !== expected) begin
            abort_run($sformatf(
                "ERROR %0t rsp (%s): expected rdata=%h illegal=%b, actual rdata=%h illegal=%b",
                $time, name, expected.rdata, expected.illegal, rsp.rdata, rsp.illegal));
        end
    endtask

    task automatic check_priv(input csr_pkg::privilege_t expected);
        if (priv !== expected) begin
            abort_run($sformatf("ERROR %0t priv: expected %b, actual %b",
                $time, expected, priv));
        end
    endtask

    task automatic check_word(input string name, input logic [`CSR_XLEN-1:0] expected,
                              input logic [`CSR_XLEN-1:0] actual);
        if (actual !== expected) begin
            abort_run($sformatf("ERROR %0t %s: expected %h, actual %h",
                $time, name, expected, actual));
        end
    endtask

    ////////////////////////////////////////
    // Stimulus helpers

    function automatic csr_pkg::csr_req_t make_req(input logic [11:0] addr,
                                                   input csr_pkg::csr_op_t op,
                                                   input logic [`CSR_XLEN-1:0] wdata);
        csr_pkg::csr_req_t r;
        r.addr.raw = addr;
        r.op       = op;
        r.wdata    = wdata;
        return r;
    endfunction

    // Set with no bits is a plain read
    function automatic csr_pkg::csr_req_t read_req(input logic [11:0] addr);
        return make_req(addr, csr_pkg::CSR_RS, 32'h0);
    endfunction

    function automatic csr_pkg::csr_rsp_t make_rsp(input logic [`CSR_XLEN-1:0] rdata,
                                                   input logic illegal);
        csr_pkg::csr_rsp_t r;
        r.rdata   = rdata;
        r.illegal = illegal;
        return r;
    endfunction

    // mie at bit 3, mpie at bit 7, mpp at bits 12:11
    function automatic logic [`CSR_XLEN-1:0] status_word(input logic [1:0] mpp,
                                                         input logic mpie, input logic mie);
        logic [`CSR_XLEN-1:0] w;
        w        = '0;
        w[12:11] = mpp;
        w[7]     = mpie;
        w[3]     = mie;
        return w;
    endfunction

    task automatic drive_req(input csr_pkg::csr_req_t r);
        @(posedge clk);
        req_valid <= 1'b1;
        req       <= r;
    endtask

    task automatic drive_idle();
        @(posedge clk);
        req_valid <= 1'b0;
    endtask

    task automatic sample_rsp(input string name, input csr_pkg::csr_rsp_t expected);
        @(negedge clk);
        check_rsp(name, expected);
    endtask

    // Old value unknown here, only legality is checked
    task automatic sample_legal(input string name);
        @(negedge clk);
        if (!rsp_valid) begin
            abort_run($sformatf("No response for %s one cycle after its request", name));
        end
        if (rsp.illegal !== 1'b0) begin
            abort_run($sformatf("ERROR %0t rsp.illegal (%s): expected 0, actual %b",
                $time, name, rsp.illegal));
        end
    endtask

    // Back-to-back requests, each response checked while the next is decoded
    task automatic run_burst(input string name, input csr_pkg::csr_req_t reqs[$],
                             input csr_pkg::csr_rsp_t exps[$]);
        foreach (reqs[i]) begin
            drive_req(reqs[i]);
            if (i > 0) begin
                sample_rsp($sformatf("%s #%0d", name, i - 1), exps[i - 1]);
            end
        end
        drive_idle();
        sample_rsp($sformatf("%s #%0d", name, reqs.size() - 1), exps[reqs.size() - 1]);
    endtask

    task automatic pulse_trap(input logic [`CSR_XLEN-1:0] pc, input logic [3:0] code,
                              input logic [`CSR_XLEN-1:0] tval);
        csr_pkg::trap_req_t t;
        t.pc   = pc;
        t.code = code;
        t.tval = tval;
        @(posedge clk);
        trap_valid <= 1'b1;
        trap       <= t;
        @(posedge clk);
        trap_valid <= 1'b0;
    endtask

    task automatic pulse_mret();
        @(posedge clk);
        mret <= 1'b1;
        @(posedge clk);
        mret <= 1'b0;
    endtask

    ////////////////////////////////////////
    // Directed tests

    task automatic test_reset_values();
        csr_pkg::csr_req_t reqs[$];
        csr_pkg::csr_rsp_t exps[$];
        reqs.push_back(read_req(12'h300));
        exps.push_back(make_rsp(status_word(2'b11, 1'b0, 1'b0), 1'b0));
        reqs.push_back(read_req(12'h305));
        exps.push_back(make_rsp(`CSR_RESET_VEC, 1'b0));
        reqs.push_back(read_req(12'h301));
        exps.push_back(make_rsp(`CSR_MISA, 1'b0));
        reqs.push_back(read_req(12'hF14));
        exps.push_back(make_rsp(`CSR_HART_ID, 1'b0));
        reqs.push_back(read_req(12'hF13));
        exps.push_back(make_rsp(`CSR_IMPL_ID, 1'b0));
        run_burst("reset reads", reqs, exps);
        check_priv(csr_pkg::MACHINE_PRIV);
        check_word("trap_vector", `CSR_RESET_VEC, trap_vector);
    endtask

    task automatic test_read_modify_write();
        csr_pkg::csr_req_t    reqs[$];
        csr_pkg::csr_rsp_t    exps[$];
        logic [`CSR_XLEN-1:0] wd [6];
        logic [`CSR_XLEN-1:0] model;
        foreach (wd[i]) begin
            wd[i] = $urandom();
        end
        // mscratch keeps every bit
        model = '0;
        reqs.push_back(make_req(12'h340, csr_pkg::CSR_RW, wd[0]));
        exps.push_back(make_rsp(model, 1'b0));
        model = wd[0];
        reqs.push_back(make_req(12'h340, csr_pkg::CSR_RS, wd[1]));
        exps.push_back(make_rsp(model, 1'b0));
        model = model | wd[1];
        reqs.push_back(make_req(12'h340, csr_pkg::CSR_RC, wd[2]));
        exps.push_back(make_rsp(model, 1'b0));
        model = model & ~wd[2];
        reqs.push_back(read_req(12'h340));
        exps.push_back(make_rsp(model, 1'b0));
        scratch_model = model;
        // mtvec drops its low two bits
        model = `CSR_RESET_VEC;
        reqs.push_back(make_req(12'h305, csr_pkg::CSR_RW, wd[3]));
        exps.push_back(make_rsp(model, 1'b0));
        model = wd[3] & ~32'h3;
        reqs.push_back(make_req(12'h305, csr_pkg::CSR_RS, wd[4]));
        exps.push_back(make_rsp(model, 1'b0));
        model = (model | wd[4]) & ~32'h3;
        reqs.push_back(make_req(12'h305, csr_pkg::CSR_RC, wd[5]));
        exps.push_back(make_rsp(model, 1'b0));
        model = model & ~wd[5] & ~32'h3;
        reqs.push_back(read_req(12'h305));
        exps.push_back(make_rsp(model, 1'b0));
        run_burst("read-modify-write", reqs, exps);
        check_word("trap_vector", model, trap_vector);
    endtask

    task automatic test_trap_entry_return();
        csr_pkg::csr_req_t    reqs[$];
        csr_pkg::csr_rsp_t    exps[$];
        logic [`CSR_XLEN-1:0] pc;
        logic [3:0]           code;
        logic [`CSR_XLEN-1:0] tval;
        pc   = $urandom();
        code = 4'($urandom_range(15, 0));
        tval = $urandom();
        // Enable mie and clear mpp so the trap has something to stack
        reqs.push_back(make_req(12'h300, csr_pkg::CSR_RW, status_word(2'b00, 1'b0, 1'b1)));
        exps.push_back(make_rsp(status_word(2'b11, 1'b0, 1'b0), 1'b0));
        reqs.push_back(read_req(12'h300));
        exps.push_back(make_rsp(status_word(2'b00, 1'b0, 1'b1), 1'b0));
        run_burst("mie set", reqs, exps);
        pulse_trap(pc, code, tval);
        @(negedge clk);
        check_priv(csr_pkg::MACHINE_PRIV);
        check_word("epc", pc & ~32'h3, epc);
        reqs.delete();
        exps.delete();
        reqs.push_back(read_req(12'h341));
        exps.push_back(make_rsp(pc & ~32'h3, 1'b0));
        reqs.push_back(read_req(12'h342));
        exps.push_back(make_rsp({28'h0, code}, 1'b0));
        reqs.push_back(read_req(12'h343));
        exps.push_back(make_rsp(tval, 1'b0));
        // Clear mpie so the return to machine shows it set again
        reqs.push_back(make_req(12'h300, csr_pkg::CSR_RW, status_word(2'b11, 1'b0, 1'b0)));
        exps.push_back(make_rsp(status_word(2'b11, 1'b1, 1'b0), 1'b0));
        run_burst("trap entry", reqs, exps);
        pulse_mret();
        @(negedge clk);
        check_priv(csr_pkg::MACHINE_PRIV);
        reqs.delete();
        exps.delete();
        // Clear mpp so mret drops to user
        reqs.push_back(make_req(12'h300, csr_pkg::CSR_RC, 32'h1800));
        exps.push_back(make_rsp(status_word(2'b00, 1'b1, 1'b0), 1'b0));
        reqs.push_back(read_req(12'h300));
        exps.push_back(make_rsp(status_word(2'b00, 1'b1, 1'b0), 1'b0));
        run_burst("mret to machine", reqs, exps);
        pulse_mret();
        @(negedge clk);
        check_priv(csr_pkg::USER_PRIV);
    endtask

    task automatic test_access_checks();
        csr_pkg::csr_req_t    reqs[$];
        csr_pkg::csr_rsp_t    exps[$];
        logic [`CSR_XLEN-1:0] v;
        // User mode from the previous test
        reqs.push_back(read_req(12'h300));
        exps.push_back(make_rsp(32'h0, 1'b1));
        reqs.push_back(read_req(12'h305));
        exps.push_back(make_rsp(32'h0, 1'b1));
        reqs.push_back(make_req(12'h340, csr_pkg::CSR_RW, ~scratch_model));
        exps.push_back(make_rsp(32'h0, 1'b1));
        reqs.push_back(read_req(12'h341));
        exps.push_back(make_rsp(32'h0, 1'b1));
        reqs.push_back(read_req(12'hC02));
        exps.push_back(make_rsp(32'h0, 1'b0));
        run_burst("user access", reqs, exps);
        pulse_trap($urandom(), 4'($urandom_range(15, 0)), $urandom());
        @(negedge clk);
        check_priv(csr_pkg::MACHINE_PRIV);
        reqs.delete();
        exps.delete();
        reqs.push_back(read_req(12'h340));
        exps.push_back(make_rsp(scratch_model, 1'b0));
        // mie came back from mpie on mret, the trap stacks it again
        reqs.push_back(read_req(12'h300));
        exps.push_back(make_rsp(status_word(2'b00, 1'b1, 1'b0), 1'b0));
        reqs.push_back(read_req(12'h7C0));
        exps.push_back(make_rsp(32'h0, 1'b1));
        reqs.push_back(make_req(12'h306, csr_pkg::CSR_RW, $urandom()));
        exps.push_back(make_rsp(32'h0, 1'b1));
        run_burst("machine access", reqs, exps);
        // Write to the read-only cycle alias is dropped
        v = $urandom() & 32'h7FFF_FFFF;
        drive_req(make_req(12'hB00, csr_pkg::CSR_RW, v));
        drive_req(make_req(12'hC00, csr_pkg::CSR_RW, ~v));
        sample_legal("mcycle write");
        drive_req(read_req(12'hC00));
        sample_rsp("cycle alias write", make_rsp(v, 1'b0));
        drive_idle();
        sample_rsp("cycle after alias write", make_rsp(v + 32'h1, 1'b0));
    endtask

    task automatic test_counters();
        csr_pkg::csr_req_t    reqs[$];
        csr_pkg::csr_rsp_t    exps[$];
        logic [`CSR_XLEN-1:0] v;
        logic [`CSR_XLEN-1:0] h;
        int unsigned          k;
        int unsigned          n;
        v = $urandom() & 32'h7FFF_FFFF;
        h = $urandom();
        k = $urandom_range(8, 1);
        n = $urandom_range(12, 1);
        drive_req(make_req(12'hB00, csr_pkg::CSR_RW, v));
        drive_idle();
        sample_legal("mcycle write");
        repeat (k - 1) begin
            drive_idle();
        end
        drive_req(read_req(12'hC00));
        drive_idle();
        sample_rsp("mcycle k cycles on", make_rsp(v + k, 1'b0));
        reqs.push_back(make_req(12'hB80, csr_pkg::CSR_RW, h));
        exps.push_back(make_rsp(32'h0, 1'b0));
        reqs.push_back(read_req(12'hB80));
        exps.push_back(make_rsp(h, 1'b0));
        reqs.push_back(read_req(12'hC80));
        exps.push_back(make_rsp(h, 1'b0));
        run_burst("mcycleh", reqs, exps);
        for (int i = 0; i < n; i++) begin
            @(posedge clk);
            inst_retired <= 1'b1;
            @(posedge clk);
            inst_retired <= 1'b0;
            repeat ($urandom_range(2, 0)) @(posedge clk);
        end
        reqs.delete();
        exps.delete();
        reqs.push_back(read_req(12'hB02));
        exps.push_back(make_rsp(n, 1'b0));
        reqs.push_back(read_req(12'hC02));
        exps.push_back(make_rsp(n, 1'b0));
        reqs.push_back(read_req(12'hC82));
        exps.push_back(make_rsp(32'h0, 1'b0));
        run_burst("minstret", reqs, exps);
    endtask

    ////////////////////////////////////////
    // Sequence

    initial begin
        void'($urandom(32'he6ba_6008));
        rst          = 1'b1;
        req_valid    = 1'b0;
        req          = '0;
        trap_valid   = 1'b0;
        trap         = '0;
        mret         = 1'b0;
        inst_retired = 1'b0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        test_reset_values();
        test_read_modify_write();
        test_trap_entry_return();
        test_access_checks();
        test_counters();
        $display("All tests passed");
        $finish;
    end

endmodule

//--- build.f
+incdir+.
csr_pkg.sv
csr_access.sv
csr_trap.sv
csr_counter.sv
csr_read_select.sv
csr_unit.sv
csr_unit_properties.sv
csr_unit_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert \
    --top-module csr_unit_tb \
    -f build.f \
    -o csr_unit_sim
./obj_dir/csr_unit_sim
